// File: flist.f
+incdir+logic
logic/opn_bus_pkg.sv
logic/opn_timer_pkg.sv
logic/opn_reg_fsm.sv
logic/opn_prescaler.sv
logic/opn_timers.sv
logic/opn_timer_top.sv
tb/opn_clk_gen.sv
tb/opn_timer_tb.sv

// File: logic/opn_bus_pkg.sv
package opn_bus_pkg;

    // One data write as seen after the address latch
    typedef struct packed {
        logic       strobe;
        logic [7:0] num;   // Latched register number
        logic [7:0] data;
    } reg_wr_t;

    // Register 0x27 bit layout
    typedef struct packed {
        logic [1:0] rsvd;  // Channel 3 mode on the real chip
        logic       clr_b;
        logic       clr_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;
        logic       load_a;
    } tmr_ctl_fields_t;

    // Same data byte, either as control fields or as a plain value
    typedef union packed {
        tmr_ctl_fields_t fields;
        logic [7:0]      raw;
    } tmr_ctl_u;

    typedef enum logic [1:0] {
        DIV6,   // After reset
        DIV3,
        DIV2
    } div_sel_t;

endpackage

// File: logic/opn_macros.svh
`ifndef OPN_MACROS_SVH
`define OPN_MACROS_SVH

// Timer register numbers, lower bank
`define OPN_REG_TMRA_HI  8'h24  // Timer A bits 9..2
`define OPN_REG_TMRA_LO  8'h25  // Timer A bits 1..0
`define OPN_REG_TMRB     8'h26
`define OPN_REG_TMR_CTL  8'h27  // Load, enable and clear bits

// Prescaler selection
// Any data byte written here picks the ratio
`define OPN_REG_DIV6     8'h2D
`define OPN_REG_DIV3     8'h2E
`define OPN_REG_DIV2     8'h2F

// Counter widths
`define OPN_TMRA_W       10
`define OPN_TMRB_W       8

// clk_en pulses in one sample period
`define OPN_SLOTS        24

// Timer B advances once per this many zero pulses
`define OPN_TMRB_PRE     16

// Busy period length in clk_en pulses
`define OPN_BUSY_LEN     32

// cen cycles per clk_en for each prescaler setting
`define OPN_DIV6_N       6
`define OPN_DIV3_N       3
`define OPN_DIV2_N       2

`endif

// File: logic/opn_prescaler.sv
`timescale 1ns/1ps
`include "opn_macros.svh"

module opn_prescaler (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    input  opn_bus_pkg::div_sel_t div_sel,
    output logic                  clk_en,
    output logic                  zero
);
    localparam int slot_w = $clog2(`OPN_SLOTS);

    logic [2:0]        div_n;    // cen cycles per clk_en
    logic [2:0]        div_cnt;
    logic [slot_w-1:0] slot;

    always_comb begin
        case (div_sel)
            opn_bus_pkg::DIV3: div_n = 3'(`OPN_DIV3_N);
            opn_bus_pkg::DIV2: div_n = 3'(`OPN_DIV2_N);
            default:           div_n = 3'(`OPN_DIV6_N);
        endcase
    end

    // Compare with >= so a smaller ratio cuts the running period short
    assign clk_en = cen && (div_cnt >= div_n - 3'd1);
    assign zero   = clk_en && (slot == '0);  // First slot of each sample

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (clk_en) begin
            div_cnt <= '0;
        end else if (cen) begin
            div_cnt <= div_cnt + 3'd1;
        end
    end

    // Slot position within the sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (clk_en) begin
            if (slot == slot_w'(`OPN_SLOTS - 1))
                slot <= '0;
            else
                slot <= slot + 1'b1;
        end
    end

    a_zero_on_clk_en: assert property (@(posedge clk) disable iff (!rst_n)
        zero |-> clk_en);

endmodule

// File: logic/opn_reg_fsm.sv
`timescale 1ns/1ps
`include "opn_macros.svh"

module opn_reg_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clk_en,
    input  logic                      cs_n,
    input  logic                      wr_n,
    input  logic [1:0]                addr,
    input  logic [7:0]                din,
    output opn_timer_pkg::tmr_cfg_t   tmr_cfg,
    output opn_bus_pkg::div_sel_t     div_sel,
    output logic                      busy
);
    localparam int busy_w = $clog2(`OPN_BUSY_LEN);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    logic                  write;
    logic [7:0]            reg_num;
    opn_bus_pkg::reg_wr_t  wr;
    opn_bus_pkg::tmr_ctl_u ctl;
    state_t                state;
    logic [busy_w-1:0]     busy_cnt;

    assign write = !cs_n && !wr_n;

    // Register number comes from an even address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_num <= 8'd0;
        end else if (write && !addr[0]) begin
            reg_num <= din;
        end
    end

    assign wr.strobe = write && addr[0];
    assign wr.num    = reg_num;
    assign wr.data   = din;
    assign ctl.raw   = wr.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_cfg <= '0;
            div_sel <= opn_bus_pkg::DIV6;
        end else begin
            tmr_cfg.clr_a <= 1'b0;
            tmr_cfg.clr_b <= 1'b0;
            if (wr.strobe) begin
                case (wr.num)
                    `OPN_REG_TMRA_HI: tmr_cfg.value_a[`OPN_TMRA_W-1:2] <= ctl.raw;
                    `OPN_REG_TMRA_LO: tmr_cfg.value_a[1:0] <= ctl.raw[1:0];
                    `OPN_REG_TMRB:    tmr_cfg.value_b <= ctl.raw;
                    `OPN_REG_TMR_CTL: begin
                        tmr_cfg.load_a   <= ctl.fields.load_a;
                        tmr_cfg.load_b   <= ctl.fields.load_b;
                        tmr_cfg.irq_en_a <= ctl.fields.irq_en_a;
                        tmr_cfg.irq_en_b <= ctl.fields.irq_en_b;
                        // Back to back writes still give a single pulse
                        tmr_cfg.clr_a    <= ctl.fields.clr_a && !tmr_cfg.clr_a;
                        tmr_cfg.clr_b    <= ctl.fields.clr_b && !tmr_cfg.clr_b;
                    end
                    `OPN_REG_DIV6:    div_sel <= opn_bus_pkg::DIV6;
                    `OPN_REG_DIV3:    div_sel <= opn_bus_pkg::DIV3;
                    `OPN_REG_DIV2:    div_sel <= opn_bus_pkg::DIV2;
                    default: ;
                endcase
            end
        end
    end

    // Busy period, restarted by every data write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            busy_cnt <= '0;
        end else if (wr.strobe) begin
            state    <= BUSY;
            busy_cnt <= '0;
        end else if (state == BUSY && clk_en) begin
            busy_cnt <= busy_cnt + 1'b1;
            if (busy_cnt == busy_w'(`OPN_BUSY_LEN - 1))
                state <= IDLE;
        end
    end

    assign busy = (state == BUSY);

    a_clr_a_single: assert property (@(posedge clk) disable iff (!rst_n)
        tmr_cfg.clr_a |=> !tmr_cfg.clr_a);
    a_clr_b_single: assert property (@(posedge clk) disable iff (!rst_n)
        tmr_cfg.clr_b |=> !tmr_cfg.clr_b);
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(clk_en));

endmodule

// File: logic/opn_timer_pkg.sv
`include "opn_macros.svh"

package opn_timer_pkg;

    // Timer setup as held by the register file
    typedef struct packed {
        logic [`OPN_TMRA_W-1:0] value_a;
        logic [`OPN_TMRB_W-1:0] value_b;
        logic                   load_a;    // Level, counter runs while set
        logic                   load_b;
        logic                   irq_en_a;
        logic                   irq_en_b;
        logic                   clr_a;     // One clock pulse
        logic                   clr_b;
    } tmr_cfg_t;

    // Flag_a sits in bit 0, as on the status byte
    typedef struct packed {
        logic flag_b;
        logic flag_a;
    } tmr_status_t;

endpackage

// File: logic/opn_timer_top.sv
`timescale 1ns/1ps

module opn_timer_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,     // Tie high if unused
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);
    opn_timer_pkg::tmr_cfg_t    tmr_cfg;
    opn_timer_pkg::tmr_status_t tmr_status;
    opn_bus_pkg::div_sel_t      div_sel;
    logic                       busy;
    logic                       clk_en;   // Internal clock enable
    logic                       zero;     // Once per sample

    opn_reg_fsm u_reg_fsm (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .clk_en  ( clk_en   ),
        .cs_n    ( cs_n     ),
        .wr_n    ( wr_n     ),
        .addr    ( addr     ),
        .din     ( din      ),
        .tmr_cfg ( tmr_cfg  ),
        .div_sel ( div_sel  ),
        .busy    ( busy     )
    );

    opn_prescaler u_prescaler (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .cen     ( cen      ),
        .div_sel ( div_sel  ),
        .clk_en  ( clk_en   ),
        .zero    ( zero     )
    );

    opn_timers u_timers (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( zero       ),
        .tmr_cfg    ( tmr_cfg    ),
        .tmr_status ( tmr_status ),
        .irq_n      ( irq_n      )
    );

    // Status byte, same for every address
    assign dout = {busy, 5'd0, tmr_status.flag_b, tmr_status.flag_a};

endmodule

// File: logic/opn_timers.sv
`timescale 1ns/1ps
`include "opn_macros.svh"

module opn_timers (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        zero,
    input  opn_timer_pkg::tmr_cfg_t     tmr_cfg,
    output opn_timer_pkg::tmr_status_t  tmr_status,
    output logic                        irq_n
);
    localparam int pre_w = $clog2(`OPN_TMRB_PRE);

    logic [`OPN_TMRA_W-1:0] cnt_a;
    logic [`OPN_TMRB_W-1:0] cnt_b;
    logic [pre_w-1:0]       pre_b;    // Timer B sub-divider
    logic                   load_a_q;
    logic                   load_b_q;
    logic                   start_a;
    logic                   start_b;
    logic                   step_a;
    logic                   step_b;
    logic                   ovf_a;
    logic                   ovf_b;

    // Counters take their start value on a rise of the load bit
    assign start_a = tmr_cfg.load_a && !load_a_q;
    assign start_b = tmr_cfg.load_b && !load_b_q;

    assign step_a = tmr_cfg.load_a && zero && !start_a;
    assign step_b = tmr_cfg.load_b && zero && !start_b
                    && (pre_b == pre_w'(`OPN_TMRB_PRE - 1));

    assign ovf_a = step_a && (cnt_a == '1);
    assign ovf_b = step_b && (cnt_b == '1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_a_q <= 1'b0;
            cnt_a    <= '0;
        end else begin
            load_a_q <= tmr_cfg.load_a;
            if (start_a || ovf_a)
                cnt_a <= tmr_cfg.value_a;   // Reload on overflow too
            else if (step_a)
                cnt_a <= cnt_a + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_b_q <= 1'b0;
            cnt_b    <= '0;
            pre_b    <= '0;
        end else begin
            load_b_q <= tmr_cfg.load_b;
            if (start_b) begin
                cnt_b <= tmr_cfg.value_b;
                pre_b <= '0;
            end else if (tmr_cfg.load_b && zero) begin
                if (pre_b == pre_w'(`OPN_TMRB_PRE - 1))
                    pre_b <= '0;
                else
                    pre_b <= pre_b + 1'b1;
                if (ovf_b)
                    cnt_b <= tmr_cfg.value_b;
                else if (step_b)
                    cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // Flags stay set until cleared, whatever the enable does later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_status <= '0;
        end else begin
            if (tmr_cfg.clr_a)
                tmr_status.flag_a <= 1'b0;
            else if (ovf_a && tmr_cfg.irq_en_a)
                tmr_status.flag_a <= 1'b1;
            if (tmr_cfg.clr_b)
                tmr_status.flag_b <= 1'b0;
            else if (ovf_b && tmr_cfg.irq_en_b)
                tmr_status.flag_b <= 1'b1;
        end
    end

    assign irq_n = !(tmr_status.flag_a || tmr_status.flag_b);

    a_flag_a_enabled: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tmr_status.flag_a) |-> $past(tmr_cfg.irq_en_a));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the timer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module opn_timer_tb -o opn_timer_sim

./obj_dir/opn_timer_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: tb/opn_clk_gen.sv
`timescale 1ns/1ps

module opn_clk_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;   // Low from time zero
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tb/opn_timer_tb.sv
`timescale 1ns/1ps

module opn_timer_tb;
    // One line of the test file
    typedef struct packed {
        logic [7:0]  test;
        logic [7:0]  op;   // W, N, C or P
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
    } cmd_t;

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    cmd_t cmds[$];
    int   errs;         // Errors in the running test
    int   tests_ok;
    int   tests_bad;
    int   limit;        // Watchdog length in clocks
    bit   limit_ready;

    opn_clk_gen #(.period_ns(8.0), .reset_cycles(4)) u_clk_gen (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    opn_timer_top u_opn_timer_top (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cen   ( cen   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    task automatic load_tests(output bit ok);
        int          fd;
        int          t;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] lo;
        logic [31:0] hi;
        string       line;
        cmd_t        c;
        fd = $fopen("tb/opn_timer_tests.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                // Comment and blank lines fail the first scan
                if ($sscanf(line, "%d %s", t, op) == 2) begin
                    c = '0;
                    if (op == "N")
                        void'($sscanf(line, "%d %s %d", t, op, a));
                    else if (op == "P")
                        void'($sscanf(line, "%d %s %h %h %h %d %d", t, op, a, b, v, lo, hi));
                    else
                        void'($sscanf(line, "%d %s %h %h", t, op, a, b));
                    c.test = t[7:0];
                    c.op   = op;
                    c.a    = a;
                    c.b    = b;
                    c.c    = v;
                    c.d    = lo;
                    c.e    = hi;
                    cmds.push_back(c);
                    if (op == "N")
                        limit += a;
                    else if (op == "P")
                        limit += hi;
                    else
                        limit += 2;   // Write or check
                end
            end
            $fclose(fd);
            ok = (cmds.size() > 0);
        end
    endtask

    // Address or data cycle on the CPU port
    task automatic write_bus(input logic [1:0] a, input logic [7:0] d);
        @(posedge clk);
        addr <= a;
        din  <= d;
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic check_status(input logic [7:0] exp_dout, input logic exp_irq_n);
        @(negedge clk);
        assert (dout == exp_dout && irq_n == exp_irq_n) else begin
            $display("mismatch at %0t: dout %h irq_n %b, expected dout %h irq_n %b",
                     $time, dout, irq_n, exp_dout, exp_irq_n);
            errs++;
        end
    endtask

    // Wait for a status pattern and check how long it took
    task automatic poll_status(input logic [7:0] mask, input logic [7:0] val,
                               input logic exp_irq_n, input int lo, input int hi);
        int n;
        bit hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < hi) begin
            @(negedge clk);
            n++;
            hit = ((dout & mask) == val) && (irq_n == exp_irq_n);
        end
        assert (hit && n >= lo) else begin
            if (!hit)
                $display("status %h under mask %h with irq_n %b did not appear within %0d cycles",
                         val, mask, exp_irq_n, hi);
            else
                $display("status %h under mask %h came after %0d cycles, sooner than %0d",
                         val, mask, n, lo);
            errs++;
        end
    endtask

    task automatic run_cmd(input cmd_t c);
        case (c.op)
            "W": write_bus(c.a[1:0], c.b[7:0]);
            "N": repeat (c.a) @(posedge clk);
            "C": check_status(c.a[7:0], c.b[0]);
            "P": poll_status(c.a[7:0], c.b[7:0], c.c[0], c.d, c.e);
            default: begin
                $display("unknown command %s in test %0d", c.op, c.test);
                errs++;
            end
        endcase
    endtask

    task automatic report_test(input int num);
        if (errs == 0) begin
            tests_ok++;
            $display("test %0d ok", num);
        end else begin
            tests_bad++;
            $display("test %0d failed with %0d errors", num, errs);
        end
        errs = 0;
    endtask

    initial begin
        bit ok;
        int cur;
        cen         = 1'b1;
        din         = 8'h00;
        addr        = 2'b00;
        cs_n        = 1'b1;
        wr_n        = 1'b1;
        errs        = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        limit       = 0;
        limit_ready = 1'b0;
        load_tests(ok);
        if (!ok) begin
            $display("could not read any command from tb/opn_timer_tests.txt");
        end else begin
            limit       = limit + 200;   // Reset and slack
            limit_ready = 1'b1;
            wait (rst_n);
            @(posedge clk);
            cur = cmds[0].test;
            foreach (cmds[i]) begin
                if (cmds[i].test != cur) begin
                    report_test(cur);
                    cur = cmds[i].test;
                end
                run_cmd(cmds[i]);
            end
            report_test(cur);
        end
        $display("%0d tests passed, %0d tests failed", tests_ok, tests_bad);
        if (ok && tests_bad == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        wait (limit_ready);
        repeat (limit) @(posedge clk);
        $display("timeout, tests still running after %0d clocks", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: tb/opn_timer_tests.txt
# test op args, addr/data/status in hex and cycle counts in decimal
# W addr data | N cycles | C dout irq_n | P mask value irq_n min_cycles max_cycles
1 C 00 1
2 W 0 24
2 W 1 FF
2 C 80 1
2 P 80 00 1 186 195
3 W 0 25
3 W 1 00
3 W 0 27
3 W 1 05
3 P 01 01 0 432 586
4 W 1 15
4 P 01 00 1 1 5
5 W 0 26
5 W 1 FF
5 W 0 27
5 W 1 12
5 N 6912
5 C 00 1
6 W 0 2F
6 W 1 00
6 P 80 00 1 58 67
6 W 0 27
6 W 1 05
6 P 01 01 0 144 202
